/* files.f */
acc_disp_pkg.sv
acc_insn_queue.sv
acc_spec_tracker.sv
acc_req_register.sv
acc_mem_tracker.sv
acc_dispatcher.sv
acc_dispatcher_properties.sv
tb_acc_dispatcher.sv

/* Bender.yml */
package:
  name: acc_dispatcher

sources:
  - acc_disp_pkg.sv
  - acc_insn_queue.sv
  - acc_spec_tracker.sv
  - acc_req_register.sv
  - acc_mem_tracker.sv
  - acc_dispatcher.sv
  - target: test
    files:
      - acc_dispatcher_properties.sv
      - tb_acc_dispatcher.sv

/* acc_dispatcher_stim.txt */
# Columns: command, then six hex fields f0 to f5, unused ones are 0
# LEVEL ready frm cons st_pending | ISSUE fu op id insn rs1 rs2 | COMMIT id
# EXPREQ insn rs1 rs2 id op frm | QUIET n | IDLE n | FLUSH | STALL fu expected
# CDONE load store | BARRIER | HALT expected
# Committed instruction goes out with its operands and the current frm
LEVEL   1 5 0 0 0 0
STALL   3 0 0 0 0 0
ISSUE   3 0 1 0000002b 11111111 22222222
COMMIT  1 0 0 0 0 0
EXPREQ  0000002b 11111111 22222222 1 0 5
QUIET   3 0 0 0 0 0
IDLE    1 0 0 0 0 0
# Speculative instruction is never sent, not even after a flush and a late commit
ISSUE   3 0 2 0000102b 33333333 44444444
QUIET   4 0 0 0 0 0
FLUSH   0 0 0 0 0 0
COMMIT  2 0 0 0 0 0
QUIET   4 0 0 0 0 0
# Back-pressure holds the request and raises the accelerator issue stall
LEVEL   0 6 0 0 0 0
ISSUE   3 0 3 0000202b aaaa0003 bbbb0003
ISSUE   3 0 4 0000302b aaaa0004 bbbb0004
STALL   3 1 0 0 0 0
COMMIT  3 0 0 0 0 0
EXPREQ  0000202b aaaa0003 bbbb0003 3 0 6
COMMIT  4 0 0 0 0 0
IDLE    2 0 0 0 0 0
EXPREQ  0000202b aaaa0003 bbbb0003 3 0 6
LEVEL   1 7 0 0 0 0
EXPREQ  0000202b aaaa0003 bbbb0003 3 0 6
EXPREQ  0000302b aaaa0004 bbbb0004 4 0 7
STALL   3 0 0 0 0 0
IDLE    1 0 0 0 0 0
# Consistent mode stalls scalar loads and stores behind accelerator stores
LEVEL   1 0 1 0 0 0
ISSUE   3 2 5 0000402b 00001000 00000055
STALL   1 1 0 0 0 0
COMMIT  5 0 0 0 0 0
EXPREQ  0000402b 00001000 00000055 5 2 0
STALL   1 1 0 0 0 0
STALL   2 1 0 0 0 0
LEVEL   1 0 0 0 0 0
STALL   1 0 0 0 0 0
STALL   2 0 0 0 0 0
LEVEL   1 0 1 0 0 0
CDONE   0 1 0 0 0 0
STALL   1 0 0 0 0 0
STALL   2 0 0 0 0 0
# Accelerator load stalls only scalar stores
ISSUE   3 1 6 0000502b 00002000 00000000
COMMIT  6 0 0 0 0 0
EXPREQ  0000502b 00002000 00000000 6 1 0
STALL   1 0 0 0 0 0
STALL   2 1 0 0 0 0
CDONE   1 0 0 0 0 0
STALL   2 0 0 0 0 0
IDLE    1 0 0 0 0 0
# Store barrier halts the controller while stores drain
LEVEL   1 0 0 1 0 0
HALT    0 0 0 0 0 0
BARRIER 0 0 0 0 0 0
HALT    1 0 0 0 0 0
HALT    1 0 0 0 0 0
LEVEL   1 0 0 0 0 0
HALT    0 0 0 0 0 0
IDLE    2 0 0 0 0 0

/* tb_acc_dispatcher.sv */
// Testbench for the accelerator dispatcher with file stimulus and typed compare tasks
`timescale 1ns/1ps

module tb_acc_dispatcher;

  // Upper bound in cycles for any wait on the DUT
  localparam int unsigned TB_TIMEOUT = 64;

  logic                                  clk_i;
  logic                                  arst_n_i;
  logic                                  issue_hs_i;
  acc_disp_pkg::fu_e                     issue_fu_i;
  acc_disp_pkg::acc_op_e                 issue_op_i;
  logic                                  issue_ex_valid_i;
  acc_disp_pkg::trans_id_t               issue_trans_id_i;
  logic [acc_disp_pkg::XLEN-1:0]         imm_i;
  logic [acc_disp_pkg::XLEN-1:0]         operand_a_i;
  logic [acc_disp_pkg::XLEN-1:0]         operand_b_i;
  logic                                  issue_stall_o;
  logic                                  acc_valid_ex_o;
  logic                                  commit_valid_i    [acc_disp_pkg::NR_COMMIT_PORTS];
  acc_disp_pkg::fu_e                     commit_fu_i       [acc_disp_pkg::NR_COMMIT_PORTS];
  acc_disp_pkg::trans_id_t               commit_trans_id_i [acc_disp_pkg::NR_COMMIT_PORTS];
  logic                                  commit_st_barrier_i;
  logic                                  flush_unissued_i;
  logic                                  flush_ex_i;
  logic                                  cons_en_i;
  logic [acc_disp_pkg::FRM_W-1:0]        frm_i;
  logic                                  ctrl_halt_o;
  logic                                  acc_req_ready_i;
  logic                                  acc_store_pending_i;
  logic                                  acc_load_complete_i;
  logic                                  acc_store_complete_i;
  logic                                  acc_req_valid_o;
  acc_disp_pkg::acc_entry_t              acc_req_entry_o;
  logic [acc_disp_pkg::FRM_W-1:0]        acc_req_frm_o;

  acc_dispatcher acc_dispatcher_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_frm(input string name, input logic [acc_disp_pkg::FRM_W-1:0] got,
                           input logic [acc_disp_pkg::FRM_W-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_entry(input string name, input acc_disp_pkg::acc_entry_t got,
                             input acc_disp_pkg::acc_entry_t exp);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // Sum over all bound assertion instances
  function automatic int unsigned assert_errors();
    return acc_dispatcher_i.i_ld_tracker.i_props.err_cnt +
           acc_dispatcher_i.i_st_tracker.i_props.err_cnt +
           acc_dispatcher_i.i_req_register.i_props.err_cnt;
  endfunction

  // Advance to the next falling edge and return one-cycle strobes to idle
  task automatic start_cycle();
    @(negedge clk_i);
    issue_hs_i           = 1'b0;
    issue_fu_i           = acc_disp_pkg::FU_OTHER;
    commit_valid_i[0]    = 1'b0;
    commit_valid_i[1]    = 1'b0;
    commit_fu_i[0]       = acc_disp_pkg::FU_OTHER;
    commit_fu_i[1]       = acc_disp_pkg::FU_OTHER;
    flush_ex_i           = 1'b0;
    commit_st_barrier_i  = 1'b0;
    acc_load_complete_i  = 1'b0;
    acc_store_complete_i = 1'b0;
  endtask

  task automatic issue_insn(input logic [31:0] fu, op, id, insn, rs1, rs2);
    start_cycle();
    issue_hs_i       = 1'b1;
    issue_fu_i       = acc_disp_pkg::fu_e'(fu[1:0]);
    issue_op_i       = acc_disp_pkg::acc_op_e'(op[1:0]);
    issue_trans_id_i = id[acc_disp_pkg::TRANS_ID_BITS-1:0];
    imm_i            = insn;
    operand_a_i      = rs1;
    operand_b_i      = rs2;
    #1;
    start_cycle();
    #1;
    // Accepted accelerator issue shows up exactly one cycle later
    if (acc_disp_pkg::fu_e'(fu[1:0]) == acc_disp_pkg::FU_ACCEL) begin
      check_bit("acc_valid_ex_o", acc_valid_ex_o, 1'b1);
    end
  endtask

  task automatic expect_request(input acc_disp_pkg::acc_entry_t exp_entry,
                                input logic [acc_disp_pkg::FRM_W-1:0] exp_frm);
    int unsigned waited;
    waited = 0;
    while (acc_req_valid_o !== 1'b1 && waited < TB_TIMEOUT) begin
      start_cycle();
      #1;
      waited++;
    end
    if (acc_req_valid_o !== 1'b1) begin
      report_failure("Timed out waiting for an accelerator request");
    end else begin
      check_entry("acc_req_entry_o", acc_req_entry_o, exp_entry);
      check_frm("acc_req_frm_o", acc_req_frm_o, exp_frm);
      // Step past the accepting edge
      if (acc_req_ready_i) begin
        start_cycle();
        #1;
      end
    end
  endtask

  task automatic run_command(input logic [63:0] cmd, input logic [31:0] f0, f1, f2, f3, f4, f5);
    acc_disp_pkg::acc_entry_t exp_entry;
    case (cmd)
      "LEVEL": begin
        start_cycle();
        acc_req_ready_i     = f0[0];
        frm_i               = f1[acc_disp_pkg::FRM_W-1:0];
        cons_en_i           = f2[0];
        acc_store_pending_i = f3[0];
        #1;
      end
      "ISSUE": issue_insn(f0, f1, f2, f3, f4, f5);
      "COMMIT": begin
        // Free top slot carrying an accelerator instruction
        start_cycle();
        commit_fu_i[0]       = acc_disp_pkg::FU_ACCEL;
        commit_trans_id_i[0] = f0[acc_disp_pkg::TRANS_ID_BITS-1:0];
        #1;
      end
      "EXPREQ": begin
        exp_entry.insn     = f0;
        exp_entry.rs1      = f1;
        exp_entry.rs2      = f2;
        exp_entry.trans_id = f3[acc_disp_pkg::TRANS_ID_BITS-1:0];
        exp_entry.op       = acc_disp_pkg::acc_op_e'(f4[1:0]);
        expect_request(exp_entry, f5[acc_disp_pkg::FRM_W-1:0]);
      end
      "QUIET": begin
        repeat (f0) begin
          start_cycle();
          #1;
          check_bit("acc_req_valid_o", acc_req_valid_o, 1'b0);
        end
      end
      "IDLE": begin
        // Random extra gap of up to two cycles
        repeat (f0 + ($urandom % 3)) begin
          start_cycle();
          #1;
        end
      end
      "FLUSH": begin
        start_cycle();
        flush_ex_i = 1'b1;
        #1;
      end
      "STALL": begin
        start_cycle();
        issue_fu_i = acc_disp_pkg::fu_e'(f0[1:0]);
        #1;
        check_bit("issue_stall_o", issue_stall_o, f1[0]);
      end
      "CDONE": begin
        start_cycle();
        acc_load_complete_i  = f0[0];
        acc_store_complete_i = f1[0];
        #1;
      end
      "BARRIER": begin
        start_cycle();
        commit_st_barrier_i = 1'b1;
        #1;
      end
      "HALT": begin
        start_cycle();
        #1;
        check_bit("ctrl_halt_o", ctrl_halt_o, f0[0]);
      end
      default: report_failure($sformatf("Unknown stimulus command %0s", cmd));
    endcase
  endtask

  // Bound assertion counters are polled once per cycle
  always @(negedge clk_i) begin
    if (assert_errors() != 0) begin
      report_failure("A bound assertion failed");
    end
  end

  initial begin
    int                fd;
    int                cnt;
    int unsigned       seed_ret;
    logic [63:0]       cmd;
    logic [31:0]       f0, f1, f2, f3, f4, f5;
    logic [8*160-1:0]  rest;
    seed_ret = $urandom(32'h3bfa);
    arst_n_i             = 1'b0;
    issue_hs_i           = 1'b0;
    issue_fu_i           = acc_disp_pkg::FU_OTHER;
    issue_op_i           = acc_disp_pkg::ACC_OP_OTHER;
    issue_ex_valid_i     = 1'b0;
    issue_trans_id_i     = '0;
    imm_i                = '0;
    operand_a_i          = '0;
    operand_b_i          = '0;
    commit_valid_i[0]    = 1'b0;
    commit_valid_i[1]    = 1'b0;
    commit_fu_i[0]       = acc_disp_pkg::FU_OTHER;
    commit_fu_i[1]       = acc_disp_pkg::FU_OTHER;
    commit_trans_id_i[0] = '0;
    commit_trans_id_i[1] = '0;
    commit_st_barrier_i  = 1'b0;
    flush_unissued_i     = 1'b0;
    flush_ex_i           = 1'b0;
    cons_en_i            = 1'b0;
    frm_i                = '0;
    acc_req_ready_i      = 1'b0;
    acc_store_pending_i  = 1'b0;
    acc_load_complete_i  = 1'b0;
    acc_store_complete_i = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    // Accelerator stall reflects the queue usage left by reset
    issue_fu_i = acc_disp_pkg::FU_ACCEL;
    #1;
    // Quiet outputs straight out of reset
    check_bit("acc_req_valid_o", acc_req_valid_o, 1'b0);
    check_bit("acc_valid_ex_o", acc_valid_ex_o, 1'b0);
    check_bit("ctrl_halt_o", ctrl_halt_o, 1'b0);
    check_bit("issue_stall_o", issue_stall_o, 1'b0);
    fd = $fopen("acc_dispatcher_stim.txt", "r");
    if (fd == 0) begin
      report_failure("Cannot open acc_dispatcher_stim.txt");
    end
    // Comment lines start with a lone hash token
    while ($fscanf(fd, "%s", cmd) == 1) begin
      if (cmd == "#") begin
        cnt = $fgets(rest, fd);
      end else begin
        cnt = $fscanf(fd, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
        if (cnt != 6) begin
          report_failure($sformatf("Malformed stimulus line for command %0s", cmd));
        end
        run_command(cmd, f0, f1, f2, f3, f4, f5);
      end
    end
    $fclose(fd);
    start_cycle();
    #1;
    if (assert_errors() == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      report_failure("A bound assertion failed before the end of the run");
    end
  end

endmodule

/* acc_dispatcher_properties.sv */
// Bound assertions on counter wrap and request stability under back-pressure
`timescale 1ns/1ps

module acc_dispatcher_properties (
  input logic                           clk_i,
  input logic                           arst_n_i,
  input logic                           overflow_i,
  input logic                           req_valid_i,
  input logic                           req_ready_i,
  input acc_disp_pkg::acc_entry_t       req_data_i,
  input logic [acc_disp_pkg::FRM_W-1:0] req_frm_i
);

  // Failed assertions in this instance
  int unsigned err_cnt = 0;

  // Speculative and dispatched counters never wrap
  no_counter_wrap: assert property (@(posedge clk_i) disable iff (!arst_n_i) !overflow_i)
    else begin
      err_cnt++;
      $error("Accelerator memory counter wrapped");
    end

  // Refused request keeps valid, entry and rounding mode
  req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      req_valid_i && !req_ready_i |=>
      req_valid_i && $stable(req_data_i) && $stable(req_frm_i))
    else begin
      err_cnt++;
      $error("Accelerator request changed while refused");
    end

endmodule

bind acc_mem_tracker acc_dispatcher_properties i_props (
  .clk_i      (clk_i),
  .arst_n_i   (arst_n_i),
  .overflow_i (overflow_o),
  .req_valid_i(1'b0),
  .req_ready_i(1'b1),
  .req_data_i ('0),
  .req_frm_i  ('0)
);

bind acc_req_register acc_dispatcher_properties i_props (
  .clk_i      (clk_i),
  .arst_n_i   (arst_n_i),
  .overflow_i (1'b0),
  .req_valid_i(valid_o),
  .req_ready_i(ready_i),
  .req_data_i (data_o),
  .req_frm_i  (frm_o)
);

/* acc_dispatcher.sv */
// Accelerator dispatcher top with issue capture, dispatch, stall logic and store barrier
`timescale 1ns/1ps

module acc_dispatcher #(
  parameter int unsigned QueueDepth = 3,
  parameter int unsigned CntWidth   = 3
) (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  // Issue stage
  input  logic                                  issue_hs_i,
  input  acc_disp_pkg::fu_e                     issue_fu_i,
  input  acc_disp_pkg::acc_op_e                 issue_op_i,
  input  logic                                  issue_ex_valid_i,
  input  acc_disp_pkg::trans_id_t               issue_trans_id_i,
  input  logic [acc_disp_pkg::XLEN-1:0]         imm_i,
  input  logic [acc_disp_pkg::XLEN-1:0]         operand_a_i,
  input  logic [acc_disp_pkg::XLEN-1:0]         operand_b_i,
  output logic                                  issue_stall_o,
  output logic                                  acc_valid_ex_o,
  // Commit stage
  input  logic                                  commit_valid_i    [acc_disp_pkg::NR_COMMIT_PORTS],
  input  acc_disp_pkg::fu_e                     commit_fu_i       [acc_disp_pkg::NR_COMMIT_PORTS],
  input  acc_disp_pkg::trans_id_t               commit_trans_id_i [acc_disp_pkg::NR_COMMIT_PORTS],
  input  logic                                  commit_st_barrier_i,
  // Controller and CSRs
  input  logic                                  flush_unissued_i,
  input  logic                                  flush_ex_i,
  input  logic                                  cons_en_i,
  input  logic [acc_disp_pkg::FRM_W-1:0]        frm_i,
  output logic                                  ctrl_halt_o,
  // Accelerator
  input  logic                                  acc_req_ready_i,
  input  logic                                  acc_store_pending_i,
  input  logic                                  acc_load_complete_i,
  input  logic                                  acc_store_complete_i,
  output logic                                  acc_req_valid_o,
  output acc_disp_pkg::acc_entry_t              acc_req_entry_o,
  output logic [acc_disp_pkg::FRM_W-1:0]        acc_req_frm_o
);

  localparam int unsigned UsageW = $clog2(QueueDepth + 1);

  logic                     acc_valid_d, acc_valid_q;
  acc_disp_pkg::acc_entry_t entry_q;
  acc_disp_pkg::acc_entry_t head;
  logic                     queue_empty;
  logic [UsageW-1:0]        queue_usage;
  logic                     head_ready;
  logic                     req_valid;
  logic                     req_ready;
  logic                     queue_pop;
  logic                     ld_disp, st_disp;
  logic                     no_ld_pending, no_st_pending;
  logic                     halt_q;

  // Accepted accelerator issue without exception or flush
  assign acc_valid_d = issue_hs_i & ~issue_ex_valid_i & ~flush_unissued_i &
                       (issue_fu_i == acc_disp_pkg::FU_ACCEL);
  assign acc_valid_ex_o = acc_valid_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      acc_valid_q <= 1'b0;
      halt_q      <= 1'b0;
    end else begin
      acc_valid_q <= acc_valid_d;
      // Barrier halts while the accelerator still drains stores
      halt_q      <= (halt_q | commit_st_barrier_i) & acc_store_pending_i;
    end
  end

  // Entry capture, instruction word comes in on the immediate
  always_ff @(posedge clk_i) begin
    if (acc_valid_d) begin
      entry_q.insn     <= imm_i[acc_disp_pkg::INSN_W-1:0];
      entry_q.rs1      <= operand_a_i;
      entry_q.rs2      <= operand_b_i;
      entry_q.trans_id <= issue_trans_id_i;
      entry_q.op       <= issue_op_i;
    end
  end

  acc_insn_queue #(
    .QueueDepth(QueueDepth)
  ) i_insn_queue (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .flush_i (flush_ex_i),
    .push_i  (acc_valid_q),
    .data_i  (entry_q),
    .pop_i   (queue_pop),
    .data_o  (head),
    .empty_o (queue_empty),
    .usage_o (queue_usage)
  );

  acc_spec_tracker i_spec_tracker (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .recv_i           (acc_valid_q),
    .recv_id_i        (entry_q.trans_id),
    .flush_i          (flush_ex_i),
    .commit_valid_i   (commit_valid_i),
    .commit_fu_i      (commit_fu_i),
    .commit_trans_id_i(commit_trans_id_i),
    .head_id_i        (head.trans_id),
    .issued_i         (queue_pop),
    .issued_id_i      (head.trans_id),
    .head_ready_o     (head_ready)
  );

  // Head goes out only once non-speculative
  assign req_valid = ~queue_empty & head_ready;
  assign queue_pop = req_valid & req_ready;
  assign ld_disp   = queue_pop & (head.op == acc_disp_pkg::ACC_OP_LOAD);
  assign st_disp   = queue_pop & (head.op == acc_disp_pkg::ACC_OP_STORE);

  acc_req_register i_req_register (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .valid_i (req_valid),
    .data_i  (head),
    .frm_i   (frm_i),
    .ready_i (acc_req_ready_i),
    .ready_o (req_ready),
    .valid_o (acc_req_valid_o),
    .data_o  (acc_req_entry_o),
    .frm_o   (acc_req_frm_o)
  );

  acc_mem_tracker #(
    .CntWidth(CntWidth)
  ) i_ld_tracker (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .flush_i       (flush_ex_i),
    .spec_inc_i    (acc_valid_d & (issue_op_i == acc_disp_pkg::ACC_OP_LOAD)),
    .disp_i        (ld_disp),
    .complete_i    (acc_load_complete_i),
    .none_pending_o(no_ld_pending),
    .overflow_o    ()
  );

  acc_mem_tracker #(
    .CntWidth(CntWidth)
  ) i_st_tracker (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .flush_i       (flush_ex_i),
    .spec_inc_i    (acc_valid_d & (issue_op_i == acc_disp_pkg::ACC_OP_STORE)),
    .disp_i        (st_disp),
    .complete_i    (acc_store_complete_i),
    .none_pending_o(no_st_pending),
    .overflow_o    ()
  );

  // Stall decision per functional unit at issue
  always_comb begin
    case (issue_fu_i)
      // Keep one queue slot in reserve
      acc_disp_pkg::FU_ACCEL: issue_stall_o = (queue_usage >= UsageW'(QueueDepth - 1));
      // Scalar load behind an accelerator store
      acc_disp_pkg::FU_LOAD:  issue_stall_o = cons_en_i & ~no_st_pending;
      // Scalar store behind any accelerator memory access
      acc_disp_pkg::FU_STORE: issue_stall_o = cons_en_i & (~no_st_pending | ~no_ld_pending);
      default:                issue_stall_o = 1'b0;
    endcase
  end

  assign ctrl_halt_o = halt_q;

endmodule

/* acc_mem_tracker.sv */
// Speculative and dispatched counters for one kind of accelerator memory access
`timescale 1ns/1ps

module acc_mem_tracker #(
  parameter int unsigned CntWidth = 3
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic flush_i,
  input  logic spec_inc_i,
  input  logic disp_i,
  input  logic complete_i,
  output logic none_pending_o,
  output logic overflow_o
);

  logic [CntWidth-1:0] spec_d, spec_q;
  logic [CntWidth-1:0] disp_d, disp_q;
  logic                spec_wrap;
  logic                disp_wrap;

  always_comb begin
    spec_d    = spec_q;
    spec_wrap = 1'b0;
    // Issued but not yet sent, can still be flushed
    if (spec_inc_i && !disp_i) begin
      spec_d    = spec_q + 1'b1;
      spec_wrap = &spec_q;
    end else if (!spec_inc_i && disp_i) begin
      spec_d    = spec_q - 1'b1;
      spec_wrap = (spec_q == '0);
    end
    if (flush_i) begin
      spec_d    = '0;
      spec_wrap = 1'b0;
    end
  end

  always_comb begin
    disp_d    = disp_q;
    disp_wrap = 1'b0;
    // Sent to the accelerator, waits for completion
    if (disp_i && !complete_i) begin
      disp_d    = disp_q + 1'b1;
      disp_wrap = &disp_q;
    end else if (!disp_i && complete_i) begin
      disp_d    = disp_q - 1'b1;
      disp_wrap = (disp_q == '0);
    end
  end

  assign none_pending_o = (spec_q == '0) & (disp_q == '0);
  assign overflow_o     = spec_wrap | disp_wrap;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      spec_q <= '0;
      disp_q <= '0;
    end else begin
      spec_q <= spec_d;
      disp_q <= disp_d;
    end
  end

endmodule

/* acc_req_register.sv */
// One-entry fall-through register for the accelerator request and rounding mode
`timescale 1ns/1ps

module acc_req_register (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic                                valid_i,
  input  acc_disp_pkg::acc_entry_t            data_i,
  input  logic [acc_disp_pkg::FRM_W-1:0]      frm_i,
  input  logic                                ready_i,
  output logic                                ready_o,
  output logic                                valid_o,
  output acc_disp_pkg::acc_entry_t            data_o,
  output logic [acc_disp_pkg::FRM_W-1:0]      frm_o
);

  logic                             full_q;
  acc_disp_pkg::acc_entry_t         data_q;
  logic [acc_disp_pkg::FRM_W-1:0]   frm_q;
  logic                             capture;

  // Refused input is parked until the accelerator takes it
  assign capture = valid_i & ~full_q & ~ready_i;

  assign ready_o = ~full_q;
  assign valid_o = full_q | valid_i;
  assign data_o  = full_q ? data_q : data_i;
  assign frm_o   = full_q ? frm_q : frm_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      if (ready_i) full_q <= 1'b0;
    end else if (capture) begin
      full_q <= 1'b1;
    end
  end

  // Held payload
  always_ff @(posedge clk_i) begin
    if (capture) begin
      data_q <= data_i;
      frm_q  <= frm_i;
    end
  end

endmodule

/* acc_spec_tracker.sv */
// Commit-slot detection with per-transaction pending and ready bitmaps
`timescale 1ns/1ps

module acc_spec_tracker (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    recv_i,
  input  acc_disp_pkg::trans_id_t recv_id_i,
  input  logic                    flush_i,
  input  logic                    commit_valid_i    [acc_disp_pkg::NR_COMMIT_PORTS],
  input  acc_disp_pkg::fu_e       commit_fu_i       [acc_disp_pkg::NR_COMMIT_PORTS],
  input  acc_disp_pkg::trans_id_t commit_trans_id_i [acc_disp_pkg::NR_COMMIT_PORTS],
  input  acc_disp_pkg::trans_id_t head_id_i,
  input  logic                    issued_i,
  input  acc_disp_pkg::trans_id_t issued_id_i,
  output logic                    head_ready_o
);

  logic [acc_disp_pkg::NR_SB_ENTRIES-1:0] pending_d, pending_q;
  logic [acc_disp_pkg::NR_SB_ENTRIES-1:0] ready_d, ready_q;

  logic                    acc_commit;
  acc_disp_pkg::trans_id_t commit_id;
  logic                    commit_hit;

  // Accelerator instruction sits in the first free commit slot
  assign acc_commit = (!commit_valid_i[0] && commit_fu_i[0] == acc_disp_pkg::FU_ACCEL) ||
                      (commit_valid_i[0] && !commit_valid_i[1] &&
                       commit_fu_i[1] == acc_disp_pkg::FU_ACCEL);
  assign commit_id  = !commit_valid_i[0] ? commit_trans_id_i[0] : commit_trans_id_i[1];

  // Only a received instruction can become non-speculative
  assign commit_hit = acc_commit & pending_q[commit_id];

  // Head may go now if already ready or committing right this cycle
  assign head_ready_o = ready_q[head_id_i] | (commit_hit & (commit_id == head_id_i));

  always_comb begin
    pending_d = pending_q;
    ready_d   = ready_q;
    // New instruction entered the queue
    if (recv_i) begin
      pending_d[recv_id_i] = 1'b1;
    end
    // Speculative ones are dropped, committed ones stay ready
    if (flush_i) begin
      pending_d = '0;
    end
    if (commit_hit) begin
      ready_d[commit_id]   = 1'b1;
      pending_d[commit_id] = 1'b0;
    end
    // Sent towards the accelerator, clear last so it wins over commit
    if (issued_i) begin
      ready_d[issued_id_i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= '0;
      ready_q   <= '0;
    end else begin
      pending_q <= pending_d;
      ready_q   <= ready_d;
    end
  end

endmodule

/* acc_insn_queue.sv */
// Fall-through accelerator instruction FIFO with usage count and flush
`timescale 1ns/1ps

module acc_insn_queue #(
  parameter int unsigned QueueDepth = 3
) (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              flush_i,
  input  logic                              push_i,
  input  acc_disp_pkg::acc_entry_t          data_i,
  input  logic                              pop_i,
  output acc_disp_pkg::acc_entry_t          data_o,
  output logic                              empty_o,
  output logic [$clog2(QueueDepth+1)-1:0]   usage_o
);

  localparam int unsigned PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned CntW = $clog2(QueueDepth + 1);

  logic [PtrW-1:0] rd_ptr_q, wr_ptr_q;
  logic [CntW-1:0] cnt_q;
  acc_disp_pkg::acc_entry_t mem_q [QueueDepth];

  logic bypass;
  logic do_push;
  logic do_pop;

  // Empty queue with push and pop together, entry passes straight through
  assign bypass  = (cnt_q == '0) & push_i & pop_i;
  // Writes beyond capacity are dropped, upstream stalls before that
  assign do_push = push_i & (cnt_q != CntW'(QueueDepth)) & ~bypass;
  assign do_pop  = pop_i & (cnt_q != '0);

  // Head shows incoming data while empty
  assign data_o  = (cnt_q == '0) ? data_i : mem_q[rd_ptr_q];
  assign empty_o = (cnt_q == '0) & ~push_i;
  assign usage_o = cnt_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Pointers wrap at the queue depth
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(QueueDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(QueueDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!do_push && do_pop) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

/* acc_disp_pkg.sv */
// Shared widths, functional unit and operation enums, transaction ID and queue entry types
package acc_disp_pkg;

  // Operand and instruction widths
  localparam int unsigned XLEN = 32;
  localparam int unsigned INSN_W = 32;

  // Scoreboard geometry
  localparam int unsigned TRANS_ID_BITS = 3;
  localparam int unsigned NR_SB_ENTRIES = 2 ** TRANS_ID_BITS;
  localparam int unsigned NR_COMMIT_PORTS = 2;

  // Floating-point rounding mode from fcsr
  localparam int unsigned FRM_W = 3;

  // Functional unit of an issued or committing instruction
  typedef enum logic [1:0] {
    FU_OTHER,
    FU_LOAD,
    FU_STORE,
    FU_ACCEL
  } fu_e;

  // Memory behaviour of an accelerator instruction
  typedef enum logic [1:0] {
    ACC_OP_OTHER,
    ACC_OP_LOAD,
    ACC_OP_STORE
  } acc_op_e;

  typedef logic [TRANS_ID_BITS-1:0] trans_id_t;

  // One queued accelerator instruction with its operands
  typedef struct packed {
    logic [INSN_W-1:0] insn;
    logic [XLEN-1:0]   rs1;
    logic [XLEN-1:0]   rs2;
    trans_id_t         trans_id;
    acc_op_e           op;
  } acc_entry_t;

endpackage
